/* common/flash_consts.svh */
`ifndef FLASH_CONSTS_SVH
`define FLASH_CONSTS_SVH

// ************************************************************
// Command codes
// ************************************************************
`define FLASH_CMD_WAKEUP    8'hAB
`define FLASH_CMD_FAST_READ 8'h0B
`define FLASH_CMD_READ_ID   8'h9F

// ************************************************************
// Identifier and frame layout
// ************************************************************
`define FLASH_CHIP_ID       24'h010000  // Streamed MSB first, repeats

`define FLASH_ADDR_BYTES    3           // Address bytes after fast-read
`define FLASH_DUMMY_BYTES   1           // Dummy bytes before data

`endif

/* common/flash_pkg.sv */
`include "flash_consts.svh"

package flash_pkg;

    typedef enum logic [7:0] {
        cmd_wakeup    = `FLASH_CMD_WAKEUP,
        cmd_fast_read = `FLASH_CMD_FAST_READ,
        cmd_read_id   = `FLASH_CMD_READ_ID
    } flash_cmd_e;

    typedef enum logic [2:0] {
        mode_idle,      // Waiting for command byte
        mode_addr,      // Collecting address bytes
        mode_dummy,     // Skipping dummy byte
        mode_send,      // Streaming pattern bytes
        mode_id,        // Streaming identifier
        mode_ignore     // Wake-up or unknown command
    } flash_mode_e;

    typedef struct packed {
        logic       strobe;     // One cycle after the 8th bit
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic       load_data;
        logic       load_id;
        logic [7:0] data;       // Reply byte for load_data
    } tx_ctrl_t;

endpackage

/* verilog/spi_rx_shifter.sv */
`timescale 1ns/1ps

module spi_rx_shifter (
    input  logic                sclk,
    input  logic                cs,
    input  logic                si,
    output flash_pkg::rx_byte_t rx
);

    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       strobe_q;

    // ************************************************************
    // Bit counter and shift register
    // ************************************************************
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            bit_cnt   <= 3'd0;
            shift_reg <= 8'd0;
        end else begin
            bit_cnt   <= bit_cnt + 3'd1;            // Wraps every byte
            shift_reg <= {shift_reg[6:0], si};      // MSB first
        end
    end

    // Byte complete on the edge where the counter wraps
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= (bit_cnt == 3'd7);
        end
    end

    // shift_reg holds the whole byte during the strobe cycle
    assign rx = '{strobe: strobe_q, data: shift_reg};

endmodule

/* flash_cmd/flash_cmd_decoder.sv */
`timescale 1ns/1ps

`include "flash_consts.svh"

module flash_cmd_decoder (
    input  logic                sclk,
    input  logic                cs,
    input  flash_pkg::rx_byte_t rx,
    output flash_pkg::tx_ctrl_t tx_ctrl,
    output logic                unknown_cmd
);

    import flash_pkg::*;

    flash_mode_e mode;
    flash_cmd_e  cmd;
    logic [1:0]  byte_cnt;
    logic [23:0] addr;
    logic [7:0]  pattern;
    logic        addr_last;
    logic        dummy_last;
    logic        addr_shift;

    assign cmd        = flash_cmd_e'(rx.data);
    assign addr_last  = (byte_cnt == 2'(`FLASH_ADDR_BYTES - 1));
    assign dummy_last = (byte_cnt == 2'(`FLASH_DUMMY_BYTES - 1));
    assign addr_shift = rx.strobe && (mode == mode_addr);

    assign pattern = addr[23:16] ^ addr[15:8] ^ addr[7:0];   // Reply byte for addr

    // ************************************************************
    // Command FSM, steps once per received byte
    // ************************************************************
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            mode        <= mode_idle;
            byte_cnt    <= 2'd0;
            unknown_cmd <= 1'b0;
        end else if (rx.strobe) begin
            case (mode)
                mode_idle: begin
                    byte_cnt <= 2'd0;
                    case (cmd)
                        cmd_fast_read: mode <= mode_addr;
                        cmd_read_id:   mode <= mode_id;
                        cmd_wakeup:    mode <= mode_ignore;
                        default: begin
                            mode        <= mode_ignore;
                            unknown_cmd <= 1'b1;      // Sticky until cs
                        end
                    endcase
                end
                mode_addr: begin
                    if (addr_last) begin
                        byte_cnt <= 2'd0;
                        mode     <= mode_dummy;
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                mode_dummy: begin
                    if (dummy_last) begin
                        byte_cnt <= 2'd0;
                        mode     <= mode_send;
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                default: begin
                    mode <= mode;                     // send, id and ignore hold
                end
            endcase
        end
    end

    // ************************************************************
    // Transmit requests, combinational on the strobe
    // ************************************************************
    always_comb begin
        tx_ctrl = '0;
        tx_ctrl.data = pattern;
        if (rx.strobe) begin
            case (mode)
                mode_idle:  tx_ctrl.load_id   = (cmd == cmd_read_id);
                mode_dummy: tx_ctrl.load_data = dummy_last;   // First data byte
                mode_send:  tx_ctrl.load_data = 1'b1;
                default:    tx_ctrl.load_data = 1'b0;
            endcase
        end
    end

    // Address register, shifted in then stepped per reply byte
    always_ff @(posedge sclk) begin
        if (addr_shift) begin
            addr <= {addr[15:0], rx.data};
        end else if (tx_ctrl.load_data) begin
            addr <= addr + 24'd1;                     // Wraps at 24 bits
        end
    end

endmodule

/* verilog/flash_tx_shifter.sv */
`timescale 1ns/1ps

`include "flash_consts.svh"

module flash_tx_shifter (
    input  logic                sclk,
    input  logic                cs,
    input  flash_pkg::tx_ctrl_t tx_ctrl,
    output logic                so,
    output logic                so_en
);

    logic [23:0] out_reg;
    logic        rotate;

    // ************************************************************
    // Output register
    // ************************************************************
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            out_reg <= 24'd0;
            rotate  <= 1'b0;
        end else if (tx_ctrl.load_id) begin
            out_reg <= `FLASH_CHIP_ID;
            rotate  <= 1'b1;                          // Identifier repeats
        end else if (tx_ctrl.load_data) begin
            out_reg <= {tx_ctrl.data, 16'd0};
            rotate  <= 1'b0;
        end else if (rotate) begin
            out_reg <= {out_reg[22:0], out_reg[23]};
        end else begin
            out_reg <= {out_reg[22:0], 1'b0};
        end
    end

    // Enabled from the first load until cs
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            so_en <= 1'b0;
        end else if (tx_ctrl.load_id || tx_ctrl.load_data) begin
            so_en <= 1'b1;
        end
    end

    assign so = out_reg[23];                          // MSB first

endmodule

/* verilog/flash_pattern_responder.sv */
`timescale 1ns/1ps

module flash_pattern_responder (
    input  logic sclk,
    input  logic cs,
    input  logic si,
    output logic so,
    output logic so_en,
    output logic unknown_cmd
);

    import flash_pkg::*;

    rx_byte_t rx;
    tx_ctrl_t tx_ctrl;

    // ************************************************************
    // Receive, decode, transmit
    // ************************************************************
    spi_rx_shifter spi_rx_shifter_i (
        .sclk (sclk),
        .cs   (cs),
        .si   (si),
        .rx   (rx)
    );

    flash_cmd_decoder flash_cmd_decoder_i (
        .sclk        (sclk),
        .cs          (cs),
        .rx          (rx),
        .tx_ctrl     (tx_ctrl),
        .unknown_cmd (unknown_cmd)
    );

    flash_tx_shifter flash_tx_shifter_i (
        .sclk    (sclk),
        .cs      (cs),
        .tx_ctrl (tx_ctrl),
        .so      (so),
        .so_en   (so_en)
    );

endmodule

/* tb/flash_pattern_assert.sv */
`timescale 1ns/1ps

module flash_pattern_assert (
    input logic sclk,
    input logic cs,
    input logic so_en,
    input logic unknown_cmd
);

    int fail_count = 0;                 // Failed assertions so far

    // ************************************************************
    // Output rules of the responder
    // ************************************************************
    property quiet_while_deselected;
        @(posedge sclk) cs |-> (!so_en && !unknown_cmd);
    endproperty

    property reply_or_error;
        @(posedge sclk) !(so_en && unknown_cmd);
    endproperty

    property unknown_is_sticky;
        @(posedge sclk) disable iff (cs) $past(unknown_cmd) |-> unknown_cmd;
    endproperty

    quiet_a:  assert property (quiet_while_deselected)
        else begin
            $error("so_en or unknown_cmd high while cs is high");
            fail_count++;
        end
    excl_a:   assert property (reply_or_error)
        else begin
            $error("so_en and unknown_cmd high together");
            fail_count++;
        end
    sticky_a: assert property (unknown_is_sticky)
        else begin
            $error("unknown_cmd dropped before cs rose");
            fail_count++;
        end

endmodule

bind flash_pattern_responder flash_pattern_assert flash_pattern_assert_i (
    .sclk        (sclk),
    .cs          (cs),
    .so_en       (so_en),
    .unknown_cmd (unknown_cmd)
);

/* tb/tb_flash_pattern.sv */
`timescale 1ns/1ps

`include "flash_consts.svh"

module tb_flash_pattern;

    localparam int half_period  = 5;
    localparam int reset_cycles = 10;
    localparam int txn_end      = reset_cycles + 1;     // Edge to raise cs, then gap
    localparam int read_id_cycles   = 8 + 48 + txn_end;
    localparam int fast_read_cycles =
        8 * (1 + `FLASH_ADDR_BYTES + `FLASH_DUMMY_BYTES) + 32 + txn_end;
    localparam int wakeup_cycles    = 8 + 16 + txn_end;
    localparam int unknown_cycles   = 8 + 17 + txn_end + read_id_cycles;
    localparam int total_cycles = reset_cycles + read_id_cycles + 4 * fast_read_cycles
                                + wakeup_cycles + unknown_cycles;
    localparam int timeout_ns   = (total_cycles * 2 + 100) * 2 * half_period;

    logic        sclk;
    logic        cs;
    logic        si;
    logic        so;
    logic        so_en;
    logic        unknown_cmd;

    flash_pattern_responder flash_pattern_responder_i (
        .sclk        (sclk),
        .cs          (cs),
        .si          (si),
        .so          (so),
        .so_en       (so_en),
        .unknown_cmd (unknown_cmd)
    );

    always #half_period sclk = ~sclk;

    // ************************************************************
    // Reporting and checking
    // ************************************************************
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error: time %0t %s expected 0x%0h actual 0x%0h",
                                     $time, name, expected, actual));
        end
    endtask

    // XOR of the three address bytes
    function automatic logic [7:0] pattern_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    // ************************************************************
    // Bus tasks, each starts 1 ns after a rising edge
    // ************************************************************
    task automatic send_byte(input logic [7:0] value);
        int i;
        for (i = 7; i >= 0; i--) begin
            si = value[i];                              // MSB first
            @(posedge sclk);
            #1;
        end
    endtask

    // Ends on a falling edge
    task automatic read_bits(input int count, output logic [63:0] bits);
        int i;
        bits = '0;
        si   = 1'b0;
        for (i = 0; i < count; i++) begin
            @(posedge sclk);
            @(negedge sclk);
            bits = {bits[62:0], so};
            check("so_en", 64'(1'b1), 64'(so_en));
        end
    endtask

    task automatic clock_quiet(input int cycles, input logic expect_unknown);
        int i;
        si = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(posedge sclk);
            @(negedge sclk);
            check("so_en", 64'(1'b0), 64'(so_en));
            check("unknown_cmd", 64'(expect_unknown), 64'(unknown_cmd));
        end
    endtask

    task automatic check_idle();
        check("so_en", 64'(1'b0), 64'(so_en));
        check("unknown_cmd", 64'(1'b0), 64'(unknown_cmd));
        check("so", 64'(1'b0), 64'(so));
    endtask

    task automatic end_transaction();
        @(posedge sclk);
        #1;
        cs = 1'b1;
        si = 1'b0;
        repeat (reset_cycles) begin
            @(posedge sclk);
            #1;
        end
        check_idle();
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************
    task automatic test_read_id();
        logic [63:0] bits;
        cs = 1'b0;
        send_byte(`FLASH_CMD_READ_ID);
        read_bits(48, bits);
        check("so read-id", {16'd0, `FLASH_CHIP_ID, `FLASH_CHIP_ID}, bits);
        end_transaction();
    endtask

    task automatic test_fast_read(input logic [23:0] base);
        logic [63:0] bits;
        logic [23:0] a;
        int          i;
        cs = 1'b0;
        send_byte(`FLASH_CMD_FAST_READ);
        for (i = 0; i < `FLASH_ADDR_BYTES; i++) begin
            send_byte(8'(base >> (8 * (`FLASH_ADDR_BYTES - 1 - i))));
        end
        for (i = 0; i < `FLASH_DUMMY_BYTES; i++) begin
            send_byte(8'($urandom()));                  // Dummy content is ignored
        end
        read_bits(32, bits);
        for (i = 0; i < 4; i++) begin
            a = base + 24'(i);                          // Wraps at 24 bits
            check("so fast-read byte", 64'(pattern_byte(a)), 64'(bits[8 * (3 - i) +: 8]));
        end
        end_transaction();
    endtask

    task automatic test_wakeup();
        cs = 1'b0;
        send_byte(`FLASH_CMD_WAKEUP);
        clock_quiet(16, 1'b0);
        end_transaction();
    endtask

    task automatic test_unknown_cmd();
        cs = 1'b0;
        send_byte(8'h55);
        clock_quiet(17, 1'b1);                          // Flag from edge 9 on
        end_transaction();
        test_read_id();
    endtask

    initial begin
        #(timeout_ns);
        report_failure("timeout: the directed tests did not finish in time");
    end

    initial begin
        wait (flash_pattern_responder_i.flash_pattern_assert_i.fail_count != 0);
        report_failure("assertion: a responder output rule was violated");
    end

    initial begin
        sclk = 1'b0;
        cs   = 1'b1;
        si   = 1'b0;
        void'($urandom(32'hd8607e06));
        repeat (reset_cycles) @(posedge sclk);
        #1;
        check_idle();
        test_read_id();
        test_fast_read(24'($urandom()));
        test_fast_read(24'($urandom()));
        test_fast_read(24'hFFFFFE);
        test_fast_read(24'h00FFFE);                     // Carry into both upper bytes
        test_wakeup();
        test_unknown_cmd();
        $display("Test OK");
        $finish;
    end

endmodule

/* flash_pattern.f */
+incdir+common
common/flash_pkg.sv
verilog/spi_rx_shifter.sv
flash_cmd/flash_cmd_decoder.sv
verilog/flash_tx_shifter.sv
verilog/flash_pattern_responder.sv
tb/flash_pattern_assert.sv
tb/tb_flash_pattern.sv

/* Makefile */
# Verilator build and run for the SPI flash pattern responder

VERILATOR  ?= verilator
TOP        ?= tb_flash_pattern
RTL_TOP    ?= flash_pattern_responder
FILELIST   ?= flash_pattern.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/flash_consts.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
